/* bench/tb_cpu_on_board.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_on_board;
    import soc_pkg::*;

    localparam int STEP_DIV       = 4;
    localparam int CLKS_PER_BIT   = 8;
    localparam int PS2_HALF       = 20;   // Clocks per PS/2 half period
    localparam int N_ENTRIES      = 7;
    localparam int TIMEOUT_CYCLES = N_ENTRIES * 3000 + 500;
    localparam logic [5:0] IDLE_INDEX = RAM_BASE[7:2];   // Idle loop word index on LEDR_PC

    logic      CLOCK_50;
    logic      KEY0;
    logic      PS2_CLK;
    logic      PS2_DAT;
    wire       UART_TXD;
    wire [7:0] LEDG;
    wire       LEDR9;
    wire       LEDR0;
    wire [5:0] LEDR_PC;

    // Stimulus table
    byte_t tab_code [N_ENTRIES];
    logic  tab_bad  [N_ENTRIES];
    logic  tab_echo [N_ENTRIES];

    int    error_count  = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    cycle_count  = 0;
    int    irq_rises    = 0;
    logic  ledr0_q      = 1'b0;
    byte_t last_code;

    cpu_on_board #(
        .STEP_DIV     (STEP_DIV),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) dut (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .PS2_CLK  (PS2_CLK),
        .PS2_DAT  (PS2_DAT),
        .UART_TXD (UART_TXD),
        .LEDG     (LEDG),
        .LEDR9    (LEDR9),
        .LEDR0    (LEDR0),
        .LEDR_PC  (LEDR_PC)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    // Counts rising edges of the interrupt LED
    always @(negedge CLOCK_50) begin
        ledr0_q <= LEDR0;
        if (LEDR0 && !ledr0_q) begin
            irq_rises <= irq_rises + 1;
        end
    end

    task automatic set_entry(input int idx, input byte_t code, input logic bad,
                             input logic echo);
        tab_code[idx] = code;
        tab_bad[idx]  = bad;
        tab_echo[idx] = echo;
    endtask

    task automatic load_table();
        integer      seed;
        logic [31:0] rnd;
        seed = 32'hd1af_e525;
        set_entry(0, 8'h1C, 1'b0, 1'b1);
        set_entry(1, 8'h32, 1'b0, 1'b1);
        set_entry(2, 8'h21, 1'b1, 1'b0);   // Corrupted parity
        set_entry(3, 8'hF0, 1'b0, 1'b1);   // Break prefix
        for (int i = 4; i < N_ENTRIES; i++) begin
            rnd = $random(seed);
            set_entry(i, rnd[7:0], (i == 5), (i != 5));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLOCK_50);
        #1;
    endtask

    task automatic wait_neg(input int n);
        repeat (n) @(negedge CLOCK_50);
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t expected);
        if (got !== expected) begin
            $display("mismatch %s: got 0x%02h expected 0x%02h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_word_index(input string name, input logic [5:0] got,
                                    input logic [5:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got 0x%02h expected 0x%02h", name, got, expected);
            error_count++;
        end
    endtask

    // Device side of PS/2 with data changing while the clock is high
    task automatic drive_ps2_frame(input byte_t code, input logic bad_parity);
        logic [10:0] frame;
        logic        parity;
        parity = ~^code;   // Odd parity
        if (bad_parity) begin
            parity = ~parity;
        end
        frame = {1'b1, parity, code, 1'b0};   // Stop, parity, data, start
        wait_cycles(1);
        for (int b = 0; b < 11; b++) begin
            PS2_DAT = frame[b];
            wait_cycles(PS2_HALF);
            PS2_CLK = 1'b0;
            wait_cycles(PS2_HALF);
            PS2_CLK = 1'b1;
        end
        PS2_DAT = 1'b1;
    endtask

    task automatic receive_serial(output byte_t data, output logic ok);
        int waited;
        waited = 0;
        ok     = 1'b1;
        data   = '0;
        while (UART_TXD !== 1'b0 && waited < 2000) begin
            @(negedge CLOCK_50);
            waited++;
        end
        if (UART_TXD !== 1'b0) begin
            $display("no serial start bit on UART_TXD within 2000 cycles");
            error_count++;
            ok = 1'b0;
        end else begin
            wait_neg(CLKS_PER_BIT / 2);   // Middle of the start bit
            if (UART_TXD !== 1'b0) begin
                $display("start bit on UART_TXD ended too early");
                error_count++;
                ok = 1'b0;
            end
            for (int b = 0; b < 8; b++) begin
                wait_neg(CLKS_PER_BIT);
                data[b] = UART_TXD;
            end
            wait_neg(CLKS_PER_BIT);
            if (UART_TXD !== 1'b1) begin
                $display("stop bit on UART_TXD is not high");
                error_count++;
                ok = 1'b0;
            end
        end
    endtask

    task automatic expect_line_idle(input int cycles, input string when);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < cycles; n++) begin
            @(negedge CLOCK_50);
            if (UART_TXD === 1'b0) begin
                seen = 1'b1;
            end
        end
        if (seen) begin
            $display("unexpected serial start bit on UART_TXD %s", when);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail", name);
        end
    endtask

    initial begin
        byte_t got;
        logic  ok;
        logic  hb0;
        int    errs_before;
        int    rises_before;
        int    waited;
        KEY0      = 1'b0;
        PS2_CLK   = 1'b1;
        PS2_DAT   = 1'b1;
        last_code = '0;   // key_code after reset
        load_table();
        wait_cycles(16);
        KEY0 = 1'b1;

        errs_before = error_count;
        @(negedge CLOCK_50);
        check_bit("UART_TXD", UART_TXD, 1'b1);
        check_bit("LEDR0", LEDR0, 1'b0);
        check_bit("LEDR9", LEDR9, 1'b0);
        check_word_index("LEDR_PC", LEDR_PC, IDLE_INDEX);
        hb0    = LEDR9;
        waited = 0;
        while (LEDR9 === hb0 && waited < 2 * STEP_DIV) begin
            @(negedge CLOCK_50);
            waited++;
        end
        if (LEDR9 === hb0) begin
            $display("heartbeat LEDR9 did not toggle within %0d cycles", 2 * STEP_DIV);
            error_count++;
        end
        report_test("reset", errs_before);

        for (int i = 0; i < N_ENTRIES; i++) begin
            errs_before  = error_count;
            rises_before = irq_rises;
            if (tab_echo[i]) begin
                fork
                    drive_ps2_frame(tab_code[i], tab_bad[i]);
                    receive_serial(got, ok);
                join
                check_byte("LEDG", LEDG, tab_code[i]);
                check_bit("LEDR0 rise", irq_rises == rises_before + 1, 1'b1);
                if (ok) begin
                    check_byte("UART_TXD byte", got, tab_code[i]);
                end
                wait_neg(CLKS_PER_BIT);   // Past the stop bit
                check_bit("LEDR0", LEDR0, 1'b0);
                check_word_index("LEDR_PC", LEDR_PC, IDLE_INDEX);   // Back in the idle loop
                expect_line_idle(200, "after the echo");
                last_code = tab_code[i];
            end else begin
                drive_ps2_frame(tab_code[i], tab_bad[i]);
                expect_line_idle(2000, "after a dropped frame");
                check_byte("LEDG", LEDG, last_code);   // Old code kept
                check_bit("LEDR0 rise", irq_rises != rises_before, 1'b0);
                check_word_index("LEDR_PC", LEDR_PC, IDLE_INDEX);
            end
            report_test($sformatf("%0d code 0x%02h%s", i, tab_code[i],
                                  tab_bad[i] ? " bad parity" : ""), errs_before);
        end

        $display("tests %0d, passed %0d, failed %0d, check errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cpu_on_board.f */
rtl/soc_pkg.sv
rtl/ps2_receiver.sv
rtl/key_irq.sv
rtl/system_bus.sv
rtl/uart_tx.sv
rtl/mini_core.sv
rtl/cpu_on_board.sv
bench/tb_cpu_on_board.sv

/* rtl/boot.mem */
// One 32-bit word per line, instruction bytes stored in reverse order
// Interrupt routine at word 0
@000
8320007F  // lw   x1, 0x7f0(x0)
232C107E  // sw   x1, 0x7f8(x0)
73002030  // mret
// Idle loop at RAM_BASE
@100
6F000000  // jal  x0, 0

/* rtl/cpu_on_board.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_on_board #(
    parameter int STEP_DIV     = 4,
    parameter int CLKS_PER_BIT = 434     // 115200 baud from 50 MHz
) (
    input  wire        CLOCK_50,
    input  wire        KEY0,        // Reset button, pressed is low
    input  wire        PS2_CLK,
    input  wire        PS2_DAT,
    output logic       UART_TXD,
    output logic [7:0] LEDG,        // Last scan code
    output logic       LEDR9,       // Heartbeat
    output logic       LEDR0,       // Interrupt waiting
    output logic [5:0] LEDR_PC
);
    import soc_pkg::*;

    addr_t    pc;
    instr_t   instr;
    irq_vec_t irq_vector;
    logic     irq_ack;
    logic     heartbeat;
    addr_t    bus_address;
    xlen_t    bus_write_data;
    logic     bus_write_enable;
    logic     bus_read_enable;
    xlen_t    bus_read_data;
    byte_t    scan_code;
    logic     code_valid;
    byte_t    key_code;
    logic     irq_led;
    logic     uart_load;
    byte_t    uart_data;

    mini_core #(
        .STEP_DIV(STEP_DIV)
    ) u_core (
        .clk              (CLOCK_50),
        .rst_n            (KEY0),
        .instr            (instr),
        .pc               (pc),
        .irq_vector       (irq_vector),
        .irq_ack          (irq_ack),
        .heartbeat        (heartbeat),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data)
    );

    system_bus u_bus (
        .clk              (CLOCK_50),
        .pc               (pc),
        .instr            (instr),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .key_code         (key_code),
        .uart_load        (uart_load),
        .uart_data        (uart_data)
    );

    ps2_receiver u_ps2 (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .ps2_clk    (PS2_CLK),
        .ps2_dat    (PS2_DAT),
        .scan_code  (scan_code),
        .code_valid (code_valid)
    );

    key_irq u_key_irq (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .scan_code  (scan_code),
        .code_valid (code_valid),
        .irq_ack    (irq_ack),
        .key_code   (key_code),
        .irq_vector (irq_vector),
        .irq_led    (irq_led)
    );

    // A load while busy is dropped
    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart (
        .clk   (CLOCK_50),
        .rst_n (KEY0),
        .load  (uart_load),
        .data  (uart_data),
        .txd   (UART_TXD),
        .busy  ()
    );

    assign LEDG    = key_code;
    assign LEDR9   = heartbeat;
    assign LEDR0   = irq_led;
    assign LEDR_PC = pc[7:2];   // Word index, low six bits

endmodule

`default_nettype wire

/* rtl/key_irq.sv */
`timescale 1ns/1ps
`default_nettype none

module key_irq (
    input  wire               clk,
    input  wire               rst_n,
    input  wire  soc_pkg::byte_t scan_code,
    input  wire               code_valid,
    input  wire               irq_ack,
    output soc_pkg::byte_t    key_code,
    output soc_pkg::irq_vec_t irq_vector,
    output logic              irq_led
);
    import soc_pkg::*;

    // A new code wins over an ack in the same clock, so no key is lost
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_code   <= '0;
            irq_vector <= IRQ_NONE;
        end else if (code_valid) begin
            key_code   <= scan_code;
            irq_vector <= IRQ_KEY;
        end else if (irq_ack && (irq_vector != IRQ_NONE)) begin
            irq_vector <= IRQ_NONE;   // Request only once per code
        end
    end

    assign irq_led = (irq_vector != IRQ_NONE);   // Lit while the request waits

endmodule

`default_nettype wire

/* rtl/mini_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mini_core #(
    parameter int STEP_DIV = 4
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire  soc_pkg::instr_t   instr,
    output soc_pkg::addr_t          pc,
    input  wire  soc_pkg::irq_vec_t irq_vector,
    output logic                    irq_ack,
    output logic                    heartbeat,
    output soc_pkg::addr_t          bus_address,
    output soc_pkg::xlen_t          bus_write_data,
    output logic                    bus_write_enable,
    output logic                    bus_read_enable,
    input  wire  soc_pkg::xlen_t    bus_read_data
);
    import soc_pkg::*;

    localparam int CW = $clog2(STEP_DIV);

    typedef enum logic [1:0] {
        ST_EXEC,
        ST_BUBBLE,
        ST_LOAD     // Second phase of LW
    } state_t;

    state_t        state;
    logic [CW-1:0] step_cnt;
    logic          step;
    logic          in_service;
    addr_t         mepc;       // Saved return pc
    xlen_t         regs [32];
    logic [6:0]    opcode;
    logic [4:0]    rd;
    logic [4:0]    rs2;
    xlen_t         imm_u;
    xlen_t         imm_i;
    xlen_t         imm_s;
    xlen_t         imm_j;
    xlen_t         rs2_val;
    logic          irq_take;
    logic          rf_we;
    xlen_t         rf_wdata;

    assign step = (step_cnt == CW'(STEP_DIV - 1));

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign rs2    = instr[24:20];
    assign imm_u  = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_i  = {{52{instr[31]}}, instr[31:20]};
    assign imm_s  = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_j  = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];   // x0 reads as zero

    // Never break into the middle of a load
    assign irq_take = (irq_vector == IRQ_KEY) && !in_service && (state != ST_LOAD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_cnt <= '0;
        end else if (step) begin
            step_cnt <= '0;
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // Register file write select
    always_comb begin
        rf_we    = 1'b0;
        rf_wdata = imm_u;
        if (step && !irq_take) begin
            if (state == ST_LOAD) begin
                rf_we    = 1'b1;
                rf_wdata = {{32{bus_read_data[31]}}, bus_read_data[31:0]};   // LW sign-extends
            end else if (state == ST_EXEC && opcode == OPC_LUI) begin
                rf_we = 1'b1;
            end else if (state == ST_EXEC && opcode == OPC_JAL) begin
                rf_we    = 1'b1;
                rf_wdata = pc + 64'd4;   // Link address
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rf_we && (rd != 5'd0)) begin
            regs[rd] <= rf_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= ST_EXEC;
            pc               <= RAM_BASE;
            mepc             <= RAM_BASE;
            in_service       <= 1'b0;
            irq_ack          <= 1'b0;
            heartbeat        <= 1'b0;
            bus_address      <= '0;
            bus_write_data   <= '0;
            bus_write_enable <= 1'b0;
            bus_read_enable  <= 1'b0;
        end else begin
            irq_ack          <= 1'b0;   // All strobes last one clock
            bus_write_enable <= 1'b0;
            bus_read_enable  <= 1'b0;
            if (step) begin
                heartbeat <= ~heartbeat;
                if (irq_take) begin
                    mepc       <= pc;   // Instruction not yet executed
                    pc         <= ROM_BASE;
                    in_service <= 1'b1;
                    irq_ack    <= 1'b1;
                    state      <= ST_BUBBLE;
                end else begin
                    case (state)
                        ST_BUBBLE: state <= ST_EXEC;
                        ST_LOAD: begin
                            pc    <= pc + 64'd4;
                            state <= ST_EXEC;
                        end
                        default: begin
                            if (instr == MRET_WORD) begin
                                pc         <= mepc;
                                in_service <= 1'b0;
                                state      <= ST_BUBBLE;
                            end else begin
                                case (opcode)
                                    OPC_JAL: begin
                                        pc    <= pc + imm_j;
                                        state <= ST_BUBBLE;
                                    end
                                    OPC_LOAD: begin     // Base is always x0
                                        bus_address     <= imm_i;
                                        bus_read_enable <= 1'b1;
                                        state           <= ST_LOAD;
                                    end
                                    OPC_STORE: begin
                                        bus_address      <= imm_s;
                                        bus_write_data   <= rs2_val;
                                        bus_write_enable <= 1'b1;
                                        pc               <= pc + 64'd4;
                                    end
                                    default: pc <= pc + 64'd4;   // LUI, unknown as nop
                                endcase
                            end
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/ps2_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            ps2_clk,
    input  wire            ps2_dat,
    output soc_pkg::byte_t scan_code,
    output logic           code_valid
);
    import soc_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DATA,
        ST_PARITY,
        ST_STOP
    } state_t;

    state_t     state;
    logic [2:0] clk_sync;   // Two sync stages plus history for the edge
    logic [1:0] dat_sync;
    logic       fall;
    logic       bit_in;
    byte_t      shift;
    logic [2:0] bit_cnt;
    logic       parity_ok;

    assign fall   = clk_sync[2] & ~clk_sync[1];
    assign bit_in = dat_sync[1];

    // Both lines idle high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync <= 3'b111;
            dat_sync <= 2'b11;
        end else begin
            clk_sync <= {clk_sync[1:0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
        end
    end

    // Device changes data on the rising edge, so sample on the falling one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            shift      <= '0;
            bit_cnt    <= '0;
            parity_ok  <= 1'b0;
            scan_code  <= '0;
            code_valid <= 1'b0;
        end else begin
            code_valid <= 1'b0;
            if (fall) begin
                case (state)
                    ST_IDLE: begin
                        if (!bit_in) begin      // Start bit
                            bit_cnt <= '0;
                            state   <= ST_DATA;
                        end
                    end
                    ST_DATA: begin
                        shift   <= {bit_in, shift[7:1]};   // LSB first
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= ST_PARITY;
                        end
                    end
                    ST_PARITY: begin
                        parity_ok <= ^{shift, bit_in};   // Odd parity over 9 bits
                        state     <= ST_STOP;
                    end
                    default: begin
                        // Stop bit must be high, else the frame is dropped
                        if (bit_in && parity_ok) begin
                            scan_code  <= shift;
                            code_valid <= 1'b1;
                        end
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    typedef logic [63:0] xlen_t;    // Register and bus data word
    typedef logic [63:0] addr_t;    // Byte address
    typedef logic [31:0] instr_t;
    typedef logic [7:0]  byte_t;    // Scan code or serial byte
    typedef logic [3:0]  irq_vec_t;

    // Interrupt vector values
    localparam irq_vec_t IRQ_NONE = 4'd0;
    localparam irq_vec_t IRQ_KEY  = 4'd1;   // Keyboard

    // Address map of one memory for ROM and RAM
    localparam addr_t ROM_BASE  = 64'h0000_0000_0000_0000;   // Interrupt routine
    localparam addr_t RAM_BASE  = 64'h0000_0000_0000_0400;   // Entry after reset
    localparam int    MEM_WORDS = 768;                       // 32-bit words
    localparam addr_t KEY_ADDR  = 64'h0000_0000_0000_07F0;   // Read only
    localparam addr_t UART_ADDR = 64'h0000_0000_0000_07F8;   // Write only

    // Opcodes of the supported subset
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // MRET has a single fixed encoding
    localparam instr_t MRET_WORD = 32'h3020_0073;

endpackage

`default_nettype wire

/* rtl/system_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module system_bus (
    input  wire                  clk,
    input  wire  soc_pkg::addr_t pc,
    output soc_pkg::instr_t      instr,
    input  wire  soc_pkg::addr_t bus_address,
    input  wire  soc_pkg::xlen_t bus_write_data,
    input  wire                  bus_write_enable,
    input  wire                  bus_read_enable,
    output soc_pkg::xlen_t       bus_read_data,
    input  wire  soc_pkg::byte_t key_code,
    output logic                 uart_load,
    output soc_pkg::byte_t       uart_data
);
    import soc_pkg::*;

    localparam int    AW      = $clog2(MEM_WORDS);
    localparam addr_t MEM_END = addr_t'(MEM_WORDS * 4);

    logic [31:0]   mem [MEM_WORDS];
    logic [31:0]   fetch_q;
    logic [31:0]   data_q;
    logic          key_sel_q;
    logic          rd_pend;
    logic          uart_wr_q;
    logic          key_sel;
    logic          uart_sel;
    logic          ram_sel;
    logic          uart_wr;
    logic [AW-1:0] fetch_idx;
    logic [AW-1:0] data_idx;

    initial begin
        $readmemh("rtl/boot.mem", mem);
    end

    assign fetch_idx = pc[AW+1:2];
    assign data_idx  = bus_address[AW+1:2];

    // Address decode
    assign key_sel  = (bus_address == KEY_ADDR);
    assign uart_sel = (bus_address == UART_ADDR);
    assign ram_sel  = (bus_address >= RAM_BASE) && (bus_address < MEM_END)
                      && !key_sel && !uart_sel;   // Device registers sit inside RAM

    // Instruction fetch port
    always_ff @(posedge clk) begin
        fetch_q <= mem[fetch_idx];
    end

    // Big-endian image words swapped for the little-endian core
    assign instr = {fetch_q[7:0], fetch_q[15:8], fetch_q[23:16], fetch_q[31:24]};

    // Data port writes on the enable clock
    always_ff @(posedge clk) begin
        if (bus_write_enable && ram_sel) begin
            mem[data_idx] <= bus_write_data[31:0];
        end
        if (bus_read_enable) begin
            data_q    <= mem[data_idx];
            key_sel_q <= key_sel;
        end
    end

    // Second stage holds the result until the core steps again
    always_ff @(posedge clk) begin
        rd_pend <= bus_read_enable;
        if (rd_pend) begin
            bus_read_data <= key_sel_q ? {56'd0, key_code} : {32'd0, data_q};
        end
    end

    assign uart_wr = bus_write_enable && uart_sel;

    always_ff @(posedge clk) begin
        uart_wr_q <= uart_wr;
    end

    // One load per write even if the enable were held
    assign uart_load = uart_wr && !uart_wr_q;
    assign uart_data = bus_write_data[7:0];

endmodule

`default_nettype wire

/* rtl/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 434
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  load,
    input  wire  soc_pkg::byte_t data,
    output logic                 txd,
    output logic                 busy
);

    localparam int TW = $clog2(CLKS_PER_BIT) + 1;

    logic [TW-1:0] timer;
    logic [3:0]    bits_left;   // Data bits plus stop bit still to send
    logic [8:0]    shift;
    logic          bit_done;

    assign bit_done = (timer == TW'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txd       <= 1'b1;   // Line idles high
            busy      <= 1'b0;
            timer     <= '0;
            bits_left <= '0;
            shift     <= '1;
        end else if (!busy) begin
            if (load) begin
                txd       <= 1'b0;   // Start bit
                shift     <= {1'b1, data};
                bits_left <= 4'd9;
                timer     <= '0;
                busy      <= 1'b1;
            end
        end else if (!bit_done) begin
            timer <= timer + 1'b1;
        end else begin
            timer <= '0;
            if (bits_left != 4'd0) begin
                txd       <= shift[0];   // LSB first, stop bit last
                shift     <= {1'b1, shift[8:1]};
                bits_left <= bits_left - 1'b1;
            end else begin
                busy <= 1'b0;   // Stop bit period over
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_cpu_on_board -f cpu_on_board.f
./obj_dir/Vtb_cpu_on_board > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
